/* hdl/app_channel_macros.svh */
`ifndef APP_CHANNEL_MACROS_SVH
`define APP_CHANNEL_MACROS_SVH

// slots per readout cycle, alternating ping and pong
`define APP_SLOTS 8

// capacitors in each bank
`define APP_CAPS 4

`define APP_TIMER_W 16  // idle threshold width

`define APP_COUNT_W 4  // event count width

`define APP_SYNC_STAGES 2  // tot synchronizer depth

`endif

/* hdl/tot_event_pkg.sv */
`default_nettype none

`include "app_channel_macros.svh"

package tot_event_pkg;

    // edge events from the comparator, one cycle each
    typedef struct packed {
        logic rise;
        logic fall;
    } tot_event_t;

    // static idle timeout setup
    typedef struct packed {
        logic                    enable;
        logic [`APP_TIMER_W-1:0] threshold;  // cycles after restart
    } timer_cfg_t;

endpackage

`default_nettype wire

/* hdl/channel_out_pkg.sv */
`default_nettype none

`include "app_channel_macros.svh"

package channel_out_pkg;

    typedef enum logic {
        WAIT_RISE,
        WAIT_FALL
    } seq_phase_e;

    // capacitor select lines
    typedef struct packed {
        logic [`APP_CAPS-1:0] ping;  // even slots
        logic [`APP_CAPS-1:0] pong;  // odd slots
    } bank_t;

    // one-cycle TAC strobes, one bit per slot
    typedef struct packed {
        logic [`APP_SLOTS-1:0] front;
        logic [`APP_SLOTS-1:0] back;
    } tac_t;

endpackage

`default_nettype wire

/* hdl/tot_edge_detect.sv */
`default_nettype none

`include "app_channel_macros.svh"

module tot_edge_detect (
    input  wire                        clk,
    input  wire                        rst_init,
    input  wire                        tot,
    output tot_event_pkg::tot_event_t  events
);

    logic [`APP_SYNC_STAGES-1:0] sync_q;
    logic                        last_q;   // level seen on the previous cycle
    logic                        tot_s;

    // synchronized comparator level
    assign tot_s = sync_q[`APP_SYNC_STAGES-1];

    always_ff @(posedge clk or posedge rst_init)
    begin
        if (rst_init)
        begin
            sync_q <= '0;
            last_q <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q[`APP_SYNC_STAGES-2:0], tot};
            last_q <= tot_s;
        end
    end

    always_ff @(posedge clk or posedge rst_init)
    begin
        if (rst_init)
            events <= '0;
        else
        begin
            events.rise <= tot_s & ~last_q;
            events.fall <= ~tot_s & last_q;
        end
    end

endmodule

`default_nettype wire

/* hdl/idle_timer.sv */
`default_nettype none

`include "app_channel_macros.svh"

module idle_timer (
    input  wire                        clk,
    input  wire                        rst_init,
    input  wire tot_event_pkg::timer_cfg_t cfg,
    input  wire                        restart,
    output logic                       timeout
);

    logic [`APP_TIMER_W-1:0] idle_cnt;

    // cycles since the sequencer last made progress
    always_ff @(posedge clk or posedge rst_init)
    begin
        if (rst_init)
        begin
            idle_cnt <= '0;
            timeout  <= 1'b0;
        end
        else if (!cfg.enable)
        begin
            idle_cnt <= '0;  // held while disabled
            timeout  <= 1'b0;
        end
        else if (restart)
        begin
            idle_cnt <= '0;
            timeout  <= 1'b0;
        end
        else if (idle_cnt == cfg.threshold)
        begin
            // fire once, then count the next interval from zero
            idle_cnt <= '0;
            timeout  <= 1'b1;
        end
        else
        begin
            idle_cnt <= idle_cnt + 1'b1;
            timeout  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/slot_sequencer.sv */
`default_nettype none

`include "app_channel_macros.svh"

module slot_sequencer (
    input  wire                        clk,
    input  wire                        rst_init,
    input  wire tot_event_pkg::tot_event_t events,
    input  wire                        timeout,
    output logic                       restart,
    output channel_out_pkg::bank_t     bank,
    output channel_out_pkg::tac_t      tac,
    output logic [`APP_COUNT_W-1:0]    count
);

    localparam int SLOT_W = $clog2(`APP_SLOTS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`APP_SLOTS - 1);

    logic [SLOT_W-1:0]           slot_q;
    logic [SLOT_W-1:0]           slot_next;  // k+1, wraps to 0
    logic [SLOT_W-1:0]           slot_prev;  // k-1, wraps to last
    logic [`APP_SLOTS-1:0]       slot_bit;
    channel_out_pkg::seq_phase_e phase_q;
    logic                        take_rise;
    logic                        take_fall;
    logic                        take_timeout;

    always_comb
    begin
        take_rise    = (phase_q == channel_out_pkg::WAIT_RISE) && events.rise;
        // a rise on the same cycle wins over the timer
        take_timeout = (phase_q == channel_out_pkg::WAIT_RISE) && !events.rise && timeout;
        take_fall    = (phase_q == channel_out_pkg::WAIT_FALL) && events.fall;
        restart      = take_rise | take_fall | take_timeout;
    end

    always_comb
    begin
        if (slot_q == LAST_SLOT)
            slot_next = '0;
        else
            slot_next = slot_q + 1'b1;

        if (slot_q == '0)
            slot_prev = LAST_SLOT;
        else
            slot_prev = slot_q - 1'b1;

        slot_bit = `APP_SLOTS'(1) << slot_q;
    end

    // slot, phase and count
    always_ff @(posedge clk or posedge rst_init)
    begin
        if (rst_init)
        begin
            slot_q  <= '0;
            phase_q <= channel_out_pkg::WAIT_RISE;
            count   <= '0;
        end
        else if (take_rise)
        begin
            phase_q <= channel_out_pkg::WAIT_FALL;
            count   <= count + 1'b1;
        end
        else if (take_fall)
        begin
            slot_q  <= slot_next;
            phase_q <= channel_out_pkg::WAIT_RISE;
            if (slot_q == LAST_SLOT)
                count <= '0;  // end of cycle
        end
        else if (take_timeout)
        begin
            slot_q <= slot_next;  // skipped, not counted
        end
    end

    // capacitor lines, bit k/2 of the bank picked by slot parity
    always_ff @(posedge clk or posedge rst_init)
    begin
        if (rst_init)
            bank <= '0;
        else if (take_rise)
        begin
            if (slot_q[0])
                bank.pong[slot_q[SLOT_W-1:1]] <= 1'b1;
            else
                bank.ping[slot_q[SLOT_W-1:1]] <= 1'b1;
        end
        else if (take_fall)
        begin
            // release the line held over from the previous slot
            if (slot_prev[0])
                bank.pong[slot_prev[SLOT_W-1:1]] <= 1'b0;
            else
                bank.ping[slot_prev[SLOT_W-1:1]] <= 1'b0;
        end
        else if (take_timeout)
        begin
            bank <= '0;
        end
    end

    // TAC one-shots
    always_ff @(posedge clk or posedge rst_init)
    begin
        if (rst_init)
            tac <= '0;
        else
        begin
            tac.front <= take_rise ? slot_bit : '0;
            tac.back  <= take_fall ? slot_bit : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/app_channel.sv */
`default_nettype none

`include "app_channel_macros.svh"

module app_channel (
    input  wire                        clk,
    input  wire                        rst_init,
    input  wire                        tot,
    input  wire tot_event_pkg::timer_cfg_t timer_cfg,
    output channel_out_pkg::bank_t     bank,
    output channel_out_pkg::tac_t      tac,
    output logic [`APP_COUNT_W-1:0]    count
);

    tot_event_pkg::tot_event_t events;
    logic                      timeout;
    logic                      restart;  // sequencer progress, clears idle count

    tot_edge_detect u_edge (
        .clk      (clk),
        .rst_init (rst_init),
        .tot      (tot),
        .events   (events)
    );

    idle_timer u_timer (
        .clk      (clk),
        .rst_init (rst_init),
        .cfg      (timer_cfg),
        .restart  (restart),
        .timeout  (timeout)
    );

    slot_sequencer u_seq (
        .clk      (clk),
        .rst_init (rst_init),
        .events   (events),
        .timeout  (timeout),
        .restart  (restart),
        .bank     (bank),
        .tac      (tac),
        .count    (count)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_init
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held over the first rising edges
    initial
    begin
        rst_init = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_init <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/app_channel_tb.sv */
`default_nettype none

`include "app_channel_macros.svh"

module app_channel_tb;

    localparam int PERIOD  = 10;
    localparam int HOLD    = 8;    // tot width in the timer tests
    localparam int SKIP_TH = 20;
    localparam int WRAP_TH = 38;   // 40-cycle skip period
    localparam int QUIET   = 200;

    // rough cycle length of each test
    localparam int LEN_RESET = 10;
    localparam int LEN_CYCLE = `APP_SLOTS * 2 * 21;
    localparam int LEN_SKIP  = 4 * HOLD + 2 * (SKIP_TH + 2);
    localparam int LEN_WRAP  = 12 * HOLD + 9 * (WRAP_TH + 2);
    localparam int LEN_QUIET = 2 * HOLD + QUIET;
    localparam int WATCHDOG_CYCLES =
        2 * (LEN_RESET + LEN_CYCLE + LEN_SKIP + LEN_WRAP + LEN_QUIET);

    logic                        clk;
    logic                        rst_init;
    logic                        tot;
    tot_event_pkg::timer_cfg_t   timer_cfg;
    channel_out_pkg::bank_t      bank;
    channel_out_pkg::tac_t       tac;
    logic [`APP_COUNT_W-1:0]     count;

    int                          errors;
    int                          checks;
    logic [31:0]                 lfsr_state;

    // reference model
    int                          m_slot;
    channel_out_pkg::seq_phase_e m_phase;
    channel_out_pkg::bank_t      m_bank;
    logic [`APP_COUNT_W-1:0]     m_count;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(3)) u_clk (
        .clk      (clk),
        .rst_init (rst_init)
    );

    app_channel dut (
        .clk       (clk),
        .rst_init  (rst_init),
        .tot       (tot),
        .timer_cfg (timer_cfg),
        .bank      (bank),
        .tac       (tac),
        .count     (count)
    );

    // galois step with right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // 6 to 21 cycles with one step per bit
    function automatic int random_width();
        int v;
        v = 0;
        for (int i = 0; i < 4; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return 6 + v;
    endfunction

    // even slots on ping and odd on pong at cap k/2
    function automatic channel_out_pkg::bank_t line_of(input int slot);
        channel_out_pkg::bank_t b;
        b = '0;
        if (slot % 2 == 0)
            b.ping = `APP_CAPS'(1) << (slot / 2);
        else
            b.pong = `APP_CAPS'(1) << (slot / 2);
        return b;
    endfunction

    function automatic logic [`APP_SLOTS-1:0] slot_bit_of(input int slot);
        return `APP_SLOTS'(1) << slot;
    endfunction

    // a skip comes every threshold+2 cycles
    function automatic int idle_cycles_for(input int skips, input int threshold);
        int period;
        period = threshold + 2;
        return skips * period + period / 2 - HOLD;  // next rise mid-interval
    endfunction

    function automatic void expect_rise();
        if (m_phase == channel_out_pkg::WAIT_RISE)
        begin
            m_bank  = m_bank | line_of(m_slot);
            m_count = m_count + 1'b1;
            m_phase = channel_out_pkg::WAIT_FALL;
        end
    endfunction

    function automatic void expect_fall();
        int prev;
        prev = (m_slot + `APP_SLOTS - 1) % `APP_SLOTS;
        if (m_phase == channel_out_pkg::WAIT_FALL)
        begin
            m_bank = m_bank & ~line_of(prev);
            if (m_slot == `APP_SLOTS - 1)
                m_count = '0;  // end of cycle
            m_slot  = (m_slot + 1) % `APP_SLOTS;
            m_phase = channel_out_pkg::WAIT_RISE;
        end
    endfunction

    function automatic void expect_skip();
        if (m_phase == channel_out_pkg::WAIT_RISE)
        begin
            m_bank = '0;
            m_slot = (m_slot + 1) % `APP_SLOTS;
        end
    endfunction

    task automatic compare_bank(input channel_out_pkg::bank_t got,
                                input channel_out_pkg::bank_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR bank: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic compare_tac(input channel_out_pkg::tac_t got,
                               input channel_out_pkg::tac_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR tac: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic compare_count(input logic [`APP_COUNT_W-1:0] got,
                                 input logic [`APP_COUNT_W-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR count: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_levels();
        compare_bank(bank, m_bank);
        compare_count(count, m_count);
    endtask

    task automatic set_timer(input logic enable, input int threshold);
        @(posedge clk);
        timer_cfg.enable    <= enable;
        timer_cfg.threshold <= `APP_TIMER_W'(threshold);
    endtask

    // one tot edge held for hold cycles while tac is watched for its one-shot
    task automatic drive_edge(input logic level, input int hold,
                              input channel_out_pkg::tac_t pulse);
        int    seen;
        string kind;
        seen = 0;
        kind = level ? "front" : "back";
        @(posedge clk);
        tot <= level;
        for (int i = 0; i < hold; i++)
        begin
            @(negedge clk);
            if (tac != '0)
            begin
                seen++;
                compare_tac(tac, pulse);
            end
        end
        checks++;
        if (seen != 1)
        begin
            errors++;
            $display("%s TAC pulse of slot %0d seen %0d times instead of once at %0t",
                     kind, m_slot, seen, $time);
        end
    endtask

    task automatic tot_pulse(input int high, input int low);
        channel_out_pkg::tac_t pulse;
        pulse       = '0;
        pulse.front = slot_bit_of(m_slot);
        drive_edge(1'b1, high, pulse);
        expect_rise();
        check_levels();
        pulse      = '0;
        pulse.back = slot_bit_of(m_slot);
        drive_edge(1'b0, low, pulse);
        expect_fall();
        check_levels();
    endtask

    task automatic wait_idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic check_reset_state();
        channel_out_pkg::tac_t no_pulse;
        no_pulse = '0;
        @(negedge clk);
        check_levels();
        compare_tac(tac, no_pulse);
    endtask

    task automatic run_full_cycle();
        int high;
        int low;
        for (int i = 0; i < `APP_SLOTS; i++)
        begin
            high = random_width();
            low  = random_width();
            tot_pulse(high, low);
        end
        compare_count(count, '0);
    endtask

    task automatic skip_on_timeout();
        set_timer(1'b1, SKIP_TH);
        tot_pulse(HOLD, HOLD);  // slot 0
        wait_idle(idle_cycles_for(1, SKIP_TH));
        expect_skip();
        check_levels();
        tot_pulse(HOLD, HOLD);
    endtask

    task automatic wrap_on_timeout();
        set_timer(1'b1, WRAP_TH);
        // walk to slot 0 so the wrap returns there
        do
        begin
            tot_pulse(HOLD, HOLD);
        end
        while (m_slot != 0);
        wait_idle(idle_cycles_for(`APP_SLOTS, WRAP_TH));
        for (int i = 0; i < `APP_SLOTS; i++)
            expect_skip();
        check_levels();
        tot_pulse(HOLD, HOLD);  // ping bit 0 again
    endtask

    task automatic hold_without_timer();
        set_timer(1'b0, 0);
        tot_pulse(HOLD, HOLD);
        wait_idle(QUIET);
        check_levels();  // lines still held
    endtask

    initial
    begin
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hc80f_bcd3;
        tot        = 1'b0;
        timer_cfg  = '0;
        m_slot     = 0;
        m_phase    = channel_out_pkg::WAIT_RISE;
        m_bank     = '0;
        m_count    = '0;
        wait (rst_init === 1'b1);
        wait (rst_init === 1'b0);
        check_reset_state();
        run_full_cycle();
        skip_on_timeout();
        wrap_on_timeout();
        hold_without_timer();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* app_channel.f */
+incdir+hdl
hdl/tot_event_pkg.sv
hdl/channel_out_pkg.sv
hdl/tot_edge_detect.sv
hdl/idle_timer.sv
hdl/slot_sequencer.sv
hdl/app_channel.sv
verif/tb_clock_gen.sv
verif/app_channel_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the app_channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f app_channel.f \
    --top-module app_channel_tb \
    -Mdir obj_dir -o app_channel_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/app_channel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
